// File: hw/bmu_params.svh
// Macros name bmu_pkg types so the package must compile first and upstream credits equal BMU_CMD_DEPTH
`ifndef BMU_PARAMS_SVH
`define BMU_PARAMS_SVH

//////////////////////////////
// Extension configuration
//////////////////////////////

`define BMU_B_EXT_DEFAULT bmu_pkg::ZBA_ZBB_ZBC_ZBS  // Zba, Zbb, Zbc and Zbs all present
`define BMU_ZC_EXT_DEFAULT 1'b1                      // Zcb present

//////////////////////////////
// Flow control
//////////////////////////////

`define BMU_CMD_DEPTH 4    // Queue entries and initial upstream credits
`define BMU_RSP_CREDITS 2  // Initial credits held toward the downstream

`endif

// File: hw/bmu_pkg.sv
// Types only and the instruction union assumes the standard RV32 R and I field layout
`default_nettype none

package bmu_pkg;

  //////////////////////////////
  // Configuration and opcodes
  //////////////////////////////

  typedef enum logic [1:0] {
    B_NONE,           // No bit-manip extension
    ZBA_ZBB_ZBS,      // Everything except carry-less multiply
    ZBA_ZBB_ZBC_ZBS   // Full set
  } b_ext_e;

  localparam logic [6:0] OPCODE_OP    = 7'h33;  // Register-register
  localparam logic [6:0] OPCODE_OPIMM = 7'h13;  // Register-immediate

  // ALU operation select
  typedef enum logic [4:0] {
    SH1ADD, SH2ADD, SH3ADD,                  // Zba
    MIN, MINU, MAX, MAXU,                    // Zbb compare
    ANDN, ORN, XNOR, ROL, ROR,               // Zbb logic and rotate
    ZEXT_H, SEXT_B, SEXT_H,                  // Zbb extend, also Zcb
    CLZ, CTZ, CPOP, ORC_B, REV8,             // Zbb unary
    CLMUL, CLMULH, CLMULR,                   // Zbc
    BSET, BCLR, BINV, BEXT                   // Zbs
  } alu_op_e;

  // Second operand source
  typedef enum logic [1:0] {
    OP_B_REG,   // rs2
    OP_B_IMM,   // shamt field
    OP_B_NONE   // Unary op
  } op_b_sel_e;

  //////////////////////////////
  // Decoder output
  //////////////////////////////

  typedef struct packed {
    logic      illegal;
    alu_op_e   alu_op;
    op_b_sel_e op_b_sel;
  } bmu_ctrl_t;

  localparam bmu_ctrl_t BMU_CTRL_ILLEGAL = '{illegal: 1'b1, alu_op: SH1ADD, op_b_sel: OP_B_NONE};

  // Register-register view
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } bmu_rtype_t;

  // Immediate shift view
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] shamt;   // Overlays rs2
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } bmu_itype_t;

  typedef union packed {
    bmu_rtype_t r;
    bmu_itype_t i;
  } bmu_instr_u;

endpackage

`default_nettype wire

// File: hw/bmu_b_decoder.sv
// Only OP and OP-IMM carry bit-manip encodings here and every other opcode decodes as illegal
`default_nettype none

module bmu_b_decoder #(
  parameter bmu_pkg::b_ext_e B_EXT  = bmu_pkg::B_NONE,
  parameter bit              ZC_EXT = 1'b0
) (
  input  bmu_pkg::bmu_instr_u instr_i,       // Instruction word
  input  logic                compressed_i,  // Expanded from a 16-bit encoding
  output bmu_pkg::bmu_ctrl_t  ctrl_o
);

  // Extension presence
  localparam bit EXT_ZBA = (B_EXT != bmu_pkg::B_NONE);
  localparam bit EXT_ZBB = (B_EXT != bmu_pkg::B_NONE);
  localparam bit EXT_ZBS = (B_EXT != bmu_pkg::B_NONE);
  localparam bit EXT_ZBC = (B_EXT == bmu_pkg::ZBA_ZBB_ZBC_ZBS);

  logic                 is_imm;   // OP-IMM opcode
  logic                 zcb_ok;   // Extend ops allowed
  logic                 zext_ok;  // zext.h also needs rs2 == x0
  logic [4:0]           op_raw;   // Matched operation
  logic                 legal;    // Match found and extension present
  bmu_pkg::op_b_sel_e   b_sel;

  assign is_imm  = (instr_i.i.opcode == bmu_pkg::OPCODE_OPIMM);
  assign zcb_ok  = EXT_ZBB || (ZC_EXT && compressed_i);  // Zcb covers only c.* forms
  assign zext_ok = zcb_ok && (instr_i.r.rs2 == 5'd0);

  //////////////////////////////
  // Opcode and function match
  //////////////////////////////

  always_comb begin
    op_raw = '0;
    legal  = 1'b0;
    unique case (instr_i.r.opcode)
      bmu_pkg::OPCODE_OP: begin
        unique case ({instr_i.r.funct7, instr_i.r.funct3})
          {7'b0010000, 3'b010}: {op_raw, legal} = {bmu_pkg::SH1ADD, EXT_ZBA};
          {7'b0010000, 3'b100}: {op_raw, legal} = {bmu_pkg::SH2ADD, EXT_ZBA};
          {7'b0010000, 3'b110}: {op_raw, legal} = {bmu_pkg::SH3ADD, EXT_ZBA};
          {7'b0000101, 3'b100}: {op_raw, legal} = {bmu_pkg::MIN, EXT_ZBB};
          {7'b0000101, 3'b101}: {op_raw, legal} = {bmu_pkg::MINU, EXT_ZBB};
          {7'b0000101, 3'b110}: {op_raw, legal} = {bmu_pkg::MAX, EXT_ZBB};
          {7'b0000101, 3'b111}: {op_raw, legal} = {bmu_pkg::MAXU, EXT_ZBB};
          {7'b0100000, 3'b111}: {op_raw, legal} = {bmu_pkg::ANDN, EXT_ZBB};
          {7'b0100000, 3'b110}: {op_raw, legal} = {bmu_pkg::ORN, EXT_ZBB};
          {7'b0100000, 3'b100}: {op_raw, legal} = {bmu_pkg::XNOR, EXT_ZBB};
          {7'b0110000, 3'b001}: {op_raw, legal} = {bmu_pkg::ROL, EXT_ZBB};
          {7'b0110000, 3'b101}: {op_raw, legal} = {bmu_pkg::ROR, EXT_ZBB};
          {7'b0000100, 3'b100}: {op_raw, legal} = {bmu_pkg::ZEXT_H, zext_ok};  // Pack with x0
          {7'b0000101, 3'b001}: {op_raw, legal} = {bmu_pkg::CLMUL, EXT_ZBC};
          {7'b0000101, 3'b011}: {op_raw, legal} = {bmu_pkg::CLMULH, EXT_ZBC};
          {7'b0000101, 3'b010}: {op_raw, legal} = {bmu_pkg::CLMULR, EXT_ZBC};
          {7'b0010100, 3'b001}: {op_raw, legal} = {bmu_pkg::BSET, EXT_ZBS};
          {7'b0100100, 3'b001}: {op_raw, legal} = {bmu_pkg::BCLR, EXT_ZBS};
          {7'b0110100, 3'b001}: {op_raw, legal} = {bmu_pkg::BINV, EXT_ZBS};
          {7'b0100100, 3'b101}: {op_raw, legal} = {bmu_pkg::BEXT, EXT_ZBS};
          default:              legal = 1'b0;  // Unknown funct7/funct3
        endcase
      end
      bmu_pkg::OPCODE_OPIMM: begin
        // Unary ops encode their function in the shamt field
        unique casez ({instr_i.i.funct7, instr_i.i.shamt, instr_i.i.funct3})
          {7'b0110000, 5'b00000, 3'b001}: {op_raw, legal} = {bmu_pkg::CLZ, EXT_ZBB};
          {7'b0110000, 5'b00001, 3'b001}: {op_raw, legal} = {bmu_pkg::CTZ, EXT_ZBB};
          {7'b0110000, 5'b00010, 3'b001}: {op_raw, legal} = {bmu_pkg::CPOP, EXT_ZBB};
          {7'b0110000, 5'b00100, 3'b001}: {op_raw, legal} = {bmu_pkg::SEXT_B, zcb_ok};
          {7'b0110000, 5'b00101, 3'b001}: {op_raw, legal} = {bmu_pkg::SEXT_H, zcb_ok};
          {7'b0010100, 5'b00111, 3'b101}: {op_raw, legal} = {bmu_pkg::ORC_B, EXT_ZBB};
          {7'b0110100, 5'b11000, 3'b101}: {op_raw, legal} = {bmu_pkg::REV8, EXT_ZBB};
          {7'b0110000, 5'b?????, 3'b101}: {op_raw, legal} = {bmu_pkg::ROR, EXT_ZBB};   // rori
          {7'b0010100, 5'b?????, 3'b001}: {op_raw, legal} = {bmu_pkg::BSET, EXT_ZBS};  // bseti
          {7'b0100100, 5'b?????, 3'b001}: {op_raw, legal} = {bmu_pkg::BCLR, EXT_ZBS};  // bclri
          {7'b0110100, 5'b?????, 3'b001}: {op_raw, legal} = {bmu_pkg::BINV, EXT_ZBS};  // binvi
          {7'b0100100, 5'b?????, 3'b101}: {op_raw, legal} = {bmu_pkg::BEXT, EXT_ZBS};  // bexti
          default:                        legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;  // Not a bit-manip opcode
    endcase
  end

  // Operand B source follows from the operation and opcode
  always_comb begin
    case (bmu_pkg::alu_op_e'(op_raw))
      bmu_pkg::ZEXT_H, bmu_pkg::SEXT_B, bmu_pkg::SEXT_H,
      bmu_pkg::CLZ, bmu_pkg::CTZ, bmu_pkg::CPOP,
      bmu_pkg::ORC_B, bmu_pkg::REV8: b_sel = bmu_pkg::OP_B_NONE;
      default:                       b_sel = is_imm ? bmu_pkg::OP_B_IMM : bmu_pkg::OP_B_REG;
    endcase
  end

  always_comb begin
    ctrl_o = bmu_pkg::BMU_CTRL_ILLEGAL;
    if (legal) begin
      ctrl_o.illegal  = 1'b0;
      ctrl_o.alu_op   = bmu_pkg::alu_op_e'(op_raw);
      ctrl_o.op_b_sel = b_sel;
    end
  end

endmodule

`default_nettype wire

// File: hw/bmu_b_alu.sv
// Single-cycle datapath and the 32-step carry-less product is the longest path in the unit
`default_nettype none

module bmu_b_alu (
  input  bmu_pkg::alu_op_e op_i,
  input  logic [31:0]      op_a_i,
  input  logic [31:0]      op_b_i,    // Only [4:0] used for shifts and bit index
  output logic [31:0]      result_o
);

  logic [4:0]  shamt;       // Rotate amount or bit index
  logic [31:0] bit_mask;    // One-hot at shamt
  logic [63:0] rol_dbl;     // Doubled word for rotate left
  logic [63:0] ror_dbl;     // Doubled word for rotate right
  logic        lt_s;
  logic        lt_u;
  logic [5:0]  clz_cnt;
  logic [5:0]  ctz_cnt;
  logic [5:0]  pop_cnt;
  logic [31:0] orc_b;
  logic [63:0] clmul_prod;  // Shared by clmul, clmulh, clmulr

  assign shamt    = op_b_i[4:0];
  assign bit_mask = 32'd1 << shamt;
  assign rol_dbl  = {op_a_i, op_a_i} << shamt;
  assign ror_dbl  = {op_a_i, op_a_i} >> shamt;
  assign lt_s     = $signed(op_a_i) < $signed(op_b_i);
  assign lt_u     = op_a_i < op_b_i;

  //////////////////////////////
  // Counts and byte ops
  //////////////////////////////

  always_comb begin
    clz_cnt = 6'd32;  // Zero input
    ctz_cnt = 6'd32;
    pop_cnt = '0;
    for (int i = 0; i < 32; i++) begin
      if (op_a_i[i]) begin
        clz_cnt = 6'(31 - i);  // Last hit is the top set bit
      end
      if (op_a_i[31 - i]) begin
        ctz_cnt = 6'(31 - i);  // Last hit is the bottom set bit
      end
      pop_cnt = pop_cnt + 6'(op_a_i[i]);
    end
  end

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      orc_b[8*b +: 8] = {8{|op_a_i[8*b +: 8]}};  // Byte all ones if any bit set
    end
  end

  // Carry-less product, XOR of shifted partials
  always_comb begin
    clmul_prod = '0;
    for (int i = 0; i < 32; i++) begin
      if (op_b_i[i]) begin
        clmul_prod = clmul_prod ^ ({32'd0, op_a_i} << i);
      end
    end
  end

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb begin
    result_o = '0;
    unique case (op_i)
      bmu_pkg::SH1ADD: result_o = (op_a_i << 1) + op_b_i;
      bmu_pkg::SH2ADD: result_o = (op_a_i << 2) + op_b_i;
      bmu_pkg::SH3ADD: result_o = (op_a_i << 3) + op_b_i;
      bmu_pkg::MIN:    result_o = lt_s ? op_a_i : op_b_i;
      bmu_pkg::MINU:   result_o = lt_u ? op_a_i : op_b_i;
      bmu_pkg::MAX:    result_o = lt_s ? op_b_i : op_a_i;
      bmu_pkg::MAXU:   result_o = lt_u ? op_b_i : op_a_i;
      bmu_pkg::ANDN:   result_o = op_a_i & ~op_b_i;
      bmu_pkg::ORN:    result_o = op_a_i | ~op_b_i;
      bmu_pkg::XNOR:   result_o = ~(op_a_i ^ op_b_i);
      bmu_pkg::ROL:    result_o = rol_dbl[63:32];
      bmu_pkg::ROR:    result_o = ror_dbl[31:0];
      bmu_pkg::ZEXT_H: result_o = {16'd0, op_a_i[15:0]};
      bmu_pkg::SEXT_B: result_o = {{24{op_a_i[7]}}, op_a_i[7:0]};
      bmu_pkg::SEXT_H: result_o = {{16{op_a_i[15]}}, op_a_i[15:0]};
      bmu_pkg::CLZ:    result_o = {26'd0, clz_cnt};
      bmu_pkg::CTZ:    result_o = {26'd0, ctz_cnt};
      bmu_pkg::CPOP:   result_o = {26'd0, pop_cnt};
      bmu_pkg::ORC_B:  result_o = orc_b;
      bmu_pkg::REV8:   result_o = {op_a_i[7:0], op_a_i[15:8], op_a_i[23:16], op_a_i[31:24]};
      bmu_pkg::CLMUL:  result_o = clmul_prod[31:0];
      bmu_pkg::CLMULH: result_o = clmul_prod[63:32];
      bmu_pkg::CLMULR: result_o = clmul_prod[62:31];  // Bit-reversed product
      bmu_pkg::BSET:   result_o = op_a_i | bit_mask;
      bmu_pkg::BCLR:   result_o = op_a_i & ~bit_mask;
      bmu_pkg::BINV:   result_o = op_a_i ^ bit_mask;
      bmu_pkg::BEXT:   result_o = {31'd0, op_a_i[shamt]};
      default:         result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/bmu_cmd_queue.sv
// Writes while full are dropped and credit_o follows each pop one cycle later
`default_nettype none
`include "bmu_params.svh"

module bmu_cmd_queue (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        wr_valid_i,       // Push, one per upstream credit
  input  logic [31:0] wr_instr_i,
  input  logic [31:0] wr_rs1_i,
  input  logic [31:0] wr_rs2_i,
  input  logic        wr_compressed_i,
  output logic        rd_valid_o,       // Head entry present
  output logic [31:0] rd_instr_o,
  output logic [31:0] rd_rs1_o,
  output logic [31:0] rd_rs2_o,
  output logic        rd_compressed_o,
  input  logic        rd_pop_i,
  output logic        credit_o          // One pulse per freed entry
);

  localparam int DEPTH = `BMU_CMD_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [31:0]      instr_mem [DEPTH];
  logic [31:0]      rs1_mem [DEPTH];
  logic [31:0]      rs2_mem [DEPTH];
  logic             cmp_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;     // Entries held
  logic             wr_en;
  logic             pop;

  // Wrapping increment for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr_en = wr_valid_i && (fill != CNT_W'(DEPTH));
  assign pop   = rd_pop_i && rd_valid_o;  // Pop on empty is ignored

  // Head entry straight from storage
  assign rd_valid_o      = (fill != '0);
  assign rd_instr_o      = instr_mem[rd_ptr];
  assign rd_rs1_o        = rs1_mem[rd_ptr];
  assign rd_rs2_o        = rs2_mem[rd_ptr];
  assign rd_compressed_o = cmp_mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      instr_mem[wr_ptr] <= wr_instr_i;
      rs1_mem[wr_ptr]   <= wr_rs1_i;
      rs2_mem[wr_ptr]   <= wr_rs2_i;
      cmp_mem[wr_ptr]   <= wr_compressed_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      credit_o <= 1'b0;
    end else begin
      credit_o <= pop;  // Registered credit return
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      fill <= fill + CNT_W'(wr_en) - CNT_W'(pop);
    end
  end

endmodule

`default_nettype wire

// File: hw/bmu_exec_stage.sv
// Operand A is always rs1 and the downstream never returns more credits than it was given
`default_nettype none
`include "bmu_params.svh"

module bmu_exec_stage #(
  parameter bmu_pkg::b_ext_e B_EXT  = `BMU_B_EXT_DEFAULT,
  parameter bit              ZC_EXT = `BMU_ZC_EXT_DEFAULT
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        q_valid_i,
  input  logic [31:0] q_instr_i,
  input  logic [31:0] q_rs1_i,
  input  logic [31:0] q_rs2_i,
  input  logic        q_compressed_i,
  output logic        q_pop_o,        // Take head entry this cycle
  output logic        rsp_valid_o,    // One-cycle pulse per result
  output logic [31:0] rsp_result_o,
  output logic        rsp_illegal_o,
  input  logic        rsp_credit_i    // One credit per pulse
);

  localparam int CRED_W = $clog2(`BMU_RSP_CREDITS + 1);

  bmu_pkg::bmu_instr_u instr;
  bmu_pkg::bmu_ctrl_t  ctrl;
  logic [31:0]         op_b;
  logic [31:0]         alu_result;
  logic [CRED_W-1:0]   credits;     // Response credits held

  assign instr   = q_instr_i;
  assign q_pop_o = q_valid_i && (credits != '0);  // Stall with no credit

  bmu_b_decoder #(
    .B_EXT  (B_EXT),
    .ZC_EXT (ZC_EXT)
  ) bmu_b_decoder_i (
    .instr_i      (instr),
    .compressed_i (q_compressed_i),
    .ctrl_o       (ctrl)
  );

  // Operand B mux
  always_comb begin
    unique case (ctrl.op_b_sel)
      bmu_pkg::OP_B_REG: op_b = q_rs2_i;
      bmu_pkg::OP_B_IMM: op_b = {27'd0, instr.i.shamt};
      default:           op_b = '0;
    endcase
  end

  bmu_b_alu bmu_b_alu_i (
    .op_i     (ctrl.alu_op),
    .op_a_i   (q_rs1_i),
    .op_b_i   (op_b),
    .result_o (alu_result)
  );

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credits     <= CRED_W'(`BMU_RSP_CREDITS);
      rsp_valid_o <= 1'b0;
    end else begin
      credits     <= credits + CRED_W'(rsp_credit_i) - CRED_W'(q_pop_o);
      rsp_valid_o <= q_pop_o;
    end
  end

  // Response payload, zero result on illegal
  always_ff @(posedge clk_i) begin
    if (q_pop_o) begin
      rsp_result_o  <= ctrl.illegal ? '0 : alu_result;
      rsp_illegal_o <= ctrl.illegal;
    end
  end

endmodule

`default_nettype wire

// File: hw/bmu_top.sv
// In-order unit and the upstream must start with BMU_CMD_DEPTH credits and send only while holding one
`default_nettype none
`include "bmu_params.svh"

module bmu_top #(
  parameter bmu_pkg::b_ext_e B_EXT  = `BMU_B_EXT_DEFAULT,
  parameter bit              ZC_EXT = `BMU_ZC_EXT_DEFAULT
) (
  input  logic        clk,
  input  logic        arst_n_i,
  // Command link
  input  logic        cmd_valid_i,
  input  logic [31:0] cmd_instr_i,
  input  logic [31:0] cmd_rs1_i,
  input  logic [31:0] cmd_rs2_i,
  input  logic        cmd_compressed_i,
  output logic        cmd_credit_o,
  // Response link
  output logic        rsp_valid_o,
  output logic [31:0] rsp_result_o,
  output logic        rsp_illegal_o,
  input  logic        rsp_credit_i
);

  // Queue head toward the execute stage
  logic        q_valid;
  logic [31:0] q_instr;
  logic [31:0] q_rs1;
  logic [31:0] q_rs2;
  logic        q_compressed;
  logic        q_pop;

  bmu_cmd_queue bmu_cmd_queue_i (
    .clk_i           (clk),
    .arst_n_i        (arst_n_i),
    .wr_valid_i      (cmd_valid_i),
    .wr_instr_i      (cmd_instr_i),
    .wr_rs1_i        (cmd_rs1_i),
    .wr_rs2_i        (cmd_rs2_i),
    .wr_compressed_i (cmd_compressed_i),
    .rd_valid_o      (q_valid),
    .rd_instr_o      (q_instr),
    .rd_rs1_o        (q_rs1),
    .rd_rs2_o        (q_rs2),
    .rd_compressed_o (q_compressed),
    .rd_pop_i        (q_pop),
    .credit_o        (cmd_credit_o)
  );

  bmu_exec_stage #(
    .B_EXT  (B_EXT),
    .ZC_EXT (ZC_EXT)
  ) bmu_exec_stage_i (
    .clk_i          (clk),
    .arst_n_i       (arst_n_i),
    .q_valid_i      (q_valid),
    .q_instr_i      (q_instr),
    .q_rs1_i        (q_rs1),
    .q_rs2_i        (q_rs2),
    .q_compressed_i (q_compressed),
    .q_pop_o        (q_pop),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_result_o   (rsp_result_o),
    .rsp_illegal_o  (rsp_illegal_o),
    .rsp_credit_i   (rsp_credit_i)
  );

endmodule

`default_nettype wire

// File: verif/bmu_clk_gen.sv
// Free-running clock that starts low at time zero and runs until the simulation ends
`default_nettype none

module bmu_clk_gen #(
  parameter int PERIOD = 8  // Full period in time units, even
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2) clk_o = ~clk_o;  // Half period per phase
    end
  end

endmodule

`default_nettype wire

// File: verif/bmu_tb.sv
// Default configuration only (all four extensions plus Zcb) and expected values are hand-computed
`default_nettype none
`include "bmu_params.svh"

module bmu_tb;

  localparam int         N_MAX    = 64;
  localparam int         RST_CYC  = 16;   // Reset length in cycles
  localparam int         WITHHOLD = 20;   // Cycles with response credits held back
  localparam int         CMD_CRED = `BMU_CMD_DEPTH;
  localparam int         RSP_CRED = `BMU_RSP_CREDITS;
  localparam logic [6:0] OP       = bmu_pkg::OPCODE_OP;
  localparam logic [6:0] IMM      = bmu_pkg::OPCODE_OPIMM;
  localparam logic [6:0] LD       = 7'h03;  // LOAD opcode, not ours

  logic        clk;
  logic        arst_n;
  logic        cmd_valid;
  logic [31:0] cmd_instr;
  logic [31:0] cmd_rs1;
  logic [31:0] cmd_rs2;
  logic        cmd_compressed;
  logic        cmd_credit;
  logic        rsp_valid;
  logic [31:0] rsp_result;
  logic        rsp_illegal;
  logic        rsp_credit;

  // Stimulus and expected values
  string       vec_name [N_MAX];
  logic [31:0] vec_instr [N_MAX];
  logic [31:0] vec_rs1 [N_MAX];
  logic [31:0] vec_rs2 [N_MAX];
  logic        vec_cmp [N_MAX];
  logic [31:0] vec_res [N_MAX];
  logic        vec_ill [N_MAX];
  int          n_vec = 0;

  int   cycles       = 0;
  int   cmd_sent     = 0;  // Commands driven so far
  int   cmd_returned = 0;  // cmd_credit_o pulses seen
  int   rsp_count    = 0;  // Responses seen
  int   rsp_granted  = 0;  // Response credits returned to the DUT
  logic withholding  = 1'b0;
  int   value_errs   = 0;
  int   flow_errs    = 0;

  bmu_clk_gen #(.PERIOD(8)) bmu_clk_gen_i (.clk_o(clk));

  bmu_top bmu_top_i (
    .clk              (clk),
    .arst_n_i         (arst_n),
    .cmd_valid_i      (cmd_valid),
    .cmd_instr_i      (cmd_instr),
    .cmd_rs1_i        (cmd_rs1),
    .cmd_rs2_i        (cmd_rs2),
    .cmd_compressed_i (cmd_compressed),
    .cmd_credit_o     (cmd_credit),
    .rsp_valid_o      (rsp_valid),
    .rsp_result_o     (rsp_result),
    .rsp_illegal_o    (rsp_illegal),
    .rsp_credit_i     (rsp_credit)
  );

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ 32'h8020_0003;
    end
    return nxt;
  endfunction

  // f5 is rs2 for R-type or shamt for OP-IMM, rs1 = x1 and rd = x3
  task automatic add_vec(input string name, input logic [6:0] f7, input logic [4:0] f5,
                         input logic [2:0] f3, input logic [6:0] opc, input logic [31:0] rs1,
                         input logic [31:0] rs2, input bit cmp, input logic [31:0] res,
                         input bit ill);
    vec_name[n_vec]  = name;
    vec_instr[n_vec] = {f7, f5, 5'd1, f3, 5'd3, opc};
    vec_rs1[n_vec]   = rs1;
    vec_rs2[n_vec]   = rs2;
    vec_cmp[n_vec]   = cmp;
    vec_res[n_vec]   = res;
    vec_ill[n_vec]   = ill;
    n_vec++;
  endtask

  //////////////////////////////
  // Vector table
  //////////////////////////////

  task automatic build_table();
    // Zba and Zbb register-register
    add_vec("sh1add", 7'h10, 5'd2, 3'd2, OP, 32'h10, 32'h5, 0, 32'h25, 0);
    add_vec("sh2add", 7'h10, 5'd2, 3'd4, OP, 32'h10, 32'h5, 0, 32'h45, 0);
    add_vec("sh3add", 7'h10, 5'd2, 3'd6, OP, 32'h80000001, 32'h1, 0, 32'h9, 0);  // Wraps
    add_vec("min", 7'h05, 5'd2, 3'd4, OP, 32'hFFFFFFFF, 32'h1, 0, 32'hFFFFFFFF, 0);
    add_vec("minu", 7'h05, 5'd2, 3'd5, OP, 32'hFFFFFFFF, 32'h1, 0, 32'h1, 0);
    add_vec("max", 7'h05, 5'd2, 3'd6, OP, 32'hFFFFFFFF, 32'h1, 0, 32'h1, 0);
    add_vec("maxu", 7'h05, 5'd2, 3'd7, OP, 32'hFFFFFFFF, 32'h1, 0, 32'hFFFFFFFF, 0);
    add_vec("andn", 7'h20, 5'd2, 3'd7, OP, 32'hF0F0F0F0, 32'hFF00FF00, 0, 32'h00F000F0, 0);
    add_vec("orn", 7'h20, 5'd2, 3'd6, OP, 32'hF0F0F0F0, 32'hFF00FF00, 0, 32'hF0FFF0FF, 0);
    add_vec("xnor", 7'h20, 5'd2, 3'd4, OP, 32'hF0F0F0F0, 32'hFF00FF00, 0, 32'hF00FF00F, 0);
    add_vec("rol", 7'h30, 5'd2, 3'd1, OP, 32'h80000001, 32'h24, 0, 32'h18, 0);  // 36 mod 32
    add_vec("ror", 7'h30, 5'd2, 3'd5, OP, 32'h18, 32'h44, 0, 32'h80000001, 0);
    add_vec("zext_h", 7'h04, 5'd0, 3'd4, OP, 32'hABCD8765, 32'hDEADBEEF, 0, 32'h8765, 0);
    // Unary and immediate, rs2 is junk
    add_vec("clz", 7'h30, 5'd0, 3'd1, IMM, 32'h00010000, 32'hDEADBEEF, 0, 32'd15, 0);
    add_vec("clz_zero", 7'h30, 5'd0, 3'd1, IMM, 32'h0, 32'hDEADBEEF, 0, 32'd32, 0);
    add_vec("clz_ones", 7'h30, 5'd0, 3'd1, IMM, 32'hFFFFFFFF, 32'hDEADBEEF, 0, 32'd0, 0);
    add_vec("ctz", 7'h30, 5'd1, 3'd1, IMM, 32'h00010000, 32'hDEADBEEF, 0, 32'd16, 0);
    add_vec("ctz_zero", 7'h30, 5'd1, 3'd1, IMM, 32'h0, 32'hDEADBEEF, 0, 32'd32, 0);
    add_vec("cpop_ones", 7'h30, 5'd2, 3'd1, IMM, 32'hFFFFFFFF, 32'hDEADBEEF, 0, 32'd32, 0);
    add_vec("cpop_zero", 7'h30, 5'd2, 3'd1, IMM, 32'h0, 32'hDEADBEEF, 0, 32'd0, 0);
    add_vec("orc_b", 7'h14, 5'd7, 3'd5, IMM, 32'h00100300, 32'hDEADBEEF, 0, 32'h00FFFF00, 0);
    add_vec("rev8", 7'h34, 5'd24, 3'd5, IMM, 32'h12345678, 32'hDEADBEEF, 0, 32'h78563412, 0);
    add_vec("sext_b", 7'h30, 5'd4, 3'd1, IMM, 32'h80, 32'hDEADBEEF, 0, 32'hFFFFFF80, 0);
    add_vec("sext_b_c", 7'h30, 5'd4, 3'd1, IMM, 32'hFFFFFF7F, 32'hDEADBEEF, 1, 32'h7F, 0);
    add_vec("sext_h", 7'h30, 5'd5, 3'd1, IMM, 32'h8000, 32'hDEADBEEF, 0, 32'hFFFF8000, 0);
    add_vec("rori", 7'h30, 5'd8, 3'd5, IMM, 32'h12345678, 32'hDEADBEEF, 0, 32'h78123456, 0);
    add_vec("bseti", 7'h14, 5'd31, 3'd1, IMM, 32'h0, 32'hDEADBEEF, 0, 32'h80000000, 0);
    add_vec("bclri", 7'h24, 5'd0, 3'd1, IMM, 32'hFFFFFFFF, 32'hDEADBEEF, 0, 32'hFFFFFFFE, 0);
    add_vec("binvi", 7'h34, 5'd16, 3'd1, IMM, 32'hFFFFFFFF, 32'hDEADBEEF, 0, 32'hFFFEFFFF, 0);
    add_vec("bexti", 7'h24, 5'd31, 3'd5, IMM, 32'h80000000, 32'hDEADBEEF, 0, 32'h1, 0);
    // Zbc and register Zbs, indices above 31 wrap
    add_vec("clmul", 7'h05, 5'd2, 3'd1, OP, 32'h3, 32'h3, 0, 32'h5, 0);
    add_vec("clmul_1s", 7'h05, 5'd2, 3'd1, OP, 32'hFFFFFFFF, 32'hFFFFFFFF, 0, 32'h55555555, 0);
    add_vec("clmulh", 7'h05, 5'd2, 3'd3, OP, 32'h80000001, 32'h80000001, 0, 32'h40000000, 0);
    add_vec("clmulh_1s", 7'h05, 5'd2, 3'd3, OP, 32'hFFFFFFFF, 32'hFFFFFFFF, 0, 32'h55555555, 0);
    add_vec("clmulr", 7'h05, 5'd2, 3'd2, OP, 32'h80000001, 32'h80000001, 0, 32'h80000000, 0);
    add_vec("clmulr_1s", 7'h05, 5'd2, 3'd2, OP, 32'hFFFFFFFF, 32'hFFFFFFFF, 0, 32'hAAAAAAAA, 0);
    add_vec("bset", 7'h14, 5'd2, 3'd1, OP, 32'h0, 32'h25, 0, 32'h20, 0);
    add_vec("bclr", 7'h24, 5'd2, 3'd1, OP, 32'hFFFFFFFF, 32'h3F, 0, 32'h7FFFFFFF, 0);
    add_vec("binv", 7'h34, 5'd2, 3'd1, OP, 32'h0000FF00, 32'h28, 0, 32'h0000FE00, 0);
    add_vec("bext", 7'h24, 5'd2, 3'd5, OP, 32'h400, 32'h4A, 0, 32'h1, 0);
    // Illegal encodings give a zero result
    add_vec("ill_funct", 7'h7F, 5'd2, 3'd0, OP, 32'h12345678, 32'h1, 0, 32'h0, 1);
    add_vec("ill_zext_rs2", 7'h04, 5'd1, 3'd4, OP, 32'h12345678, 32'h1, 0, 32'h0, 1);
    add_vec("ill_imm", 7'h30, 5'd3, 3'd1, IMM, 32'h12345678, 32'h1, 0, 32'h0, 1);
    add_vec("ill_opcode", 7'h30, 5'd2, 3'd1, LD, 32'h12345678, 32'h1, 0, 32'h0, 1);
  endtask

  //////////////////////////////
  // Command driver
  //////////////////////////////

  initial begin
    int idx;
    int avail;
    idx            = 0;
    arst_n         = 1'b0;
    cmd_valid      = 1'b0;
    cmd_instr      = '0;
    cmd_rs1        = '0;
    cmd_rs2        = '0;
    cmd_compressed = 1'b0;
    rsp_credit     = 1'b0;
    build_table();
    repeat (RST_CYC) @(posedge clk);
    arst_n <= 1'b1;
    while (idx < n_vec) begin
      @(posedge clk);
      avail = CMD_CRED + cmd_returned - idx;  // Upstream credit model
      if (avail > 0) begin
        cmd_valid      <= 1'b1;
        cmd_instr      <= vec_instr[idx];
        cmd_rs1        <= vec_rs1[idx];
        cmd_rs2        <= vec_rs2[idx];
        cmd_compressed <= vec_cmp[idx];
        idx = idx + 1;
        cmd_sent <= idx;
      end else begin
        cmd_valid <= 1'b0;  // Out of credits
      end
    end
    @(posedge clk);
    cmd_valid <= 1'b0;
    wait (rsp_count == n_vec && cmd_returned == n_vec);
    repeat (10) @(posedge clk);  // Catch stray responses or credits
    assert (rsp_count == n_vec && cmd_returned == idx) else begin
      flow_errs++;
      $display("Sent %0d commands but saw %0d responses and %0d command credits",
               idx, rsp_count, cmd_returned);
    end
    $display("Errors: %0d value, %0d flow", value_errs, flow_errs);
    if (value_errs + flow_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Response credits, held back once and then returned after random gaps
  initial begin
    logic [31:0] lfsr;
    int          gap;
    int          returned;
    lfsr     = 32'h81ec;
    returned = 0;
    wait (rsp_count >= RSP_CRED);  // Initial credits spent
    @(posedge clk);
    withholding <= 1'b1;
    repeat (WITHHOLD) @(posedge clk);
    withholding <= 1'b0;
    forever begin
      while (rsp_count <= returned) @(posedge clk);  // Nothing to give back yet
      rsp_credit <= 1'b1;
      @(posedge clk);
      rsp_credit <= 1'b0;
      returned++;
      gap = 0;
      for (int b = 0; b < 3; b++) begin
        gap  = gap | (int'(lfsr[0]) << b);  // One LFSR step per bit
        lfsr = lfsr_next(lfsr);
      end
      repeat (gap) @(posedge clk);
    end
  end

  //////////////////////////////
  // Monitor and checks
  //////////////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cmd_credit) begin
      cmd_returned <= cmd_returned + 1;
    end
    if (rsp_credit) begin
      rsp_granted <= rsp_granted + 1;
    end
    // Outputs settle after the first edge of reset
    if (cycles > 0 && cmd_sent == 0) begin
      assert (rsp_valid === 1'b0 && cmd_credit === 1'b0) else begin
        flow_errs++;
        $display("Response valid or command credit high before the first command, cycle %0d",
                 cycles);
      end
    end
    if (rsp_valid) begin
      rsp_count <= rsp_count + 1;
      assert (!withholding) else begin
        flow_errs++;
        $display("Response appeared while response credits were withheld");
      end
      assert (rsp_count < RSP_CRED + rsp_granted) else begin
        flow_errs++;
        $display("More responses than response credits granted");
      end
      assert (rsp_count < n_vec) else begin
        flow_errs++;
        $display("Response with no matching command");
      end
      if (rsp_count < n_vec) begin
        assert (rsp_result === vec_res[rsp_count] && rsp_illegal === vec_ill[rsp_count])
        else begin
          value_errs++;
          $display("** Error %s: expected result %h illegal %0b, actual result %h illegal %0b",
                   vec_name[rsp_count], vec_res[rsp_count], vec_ill[rsp_count],
                   rsp_result, rsp_illegal);
        end
      end
    end
  end

  // Watchdog, 20 cycles per vector on top of reset
  initial begin
    while (cycles < 20 * n_vec + RST_CYC) @(posedge clk);
    $display("Timeout after %0d cycles with %0d of %0d responses", cycles, rsp_count, n_vec);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/bmu_pkg.sv
hw/bmu_b_decoder.sv
hw/bmu_b_alu.sv
hw/bmu_cmd_queue.sv
hw/bmu_exec_stage.sv
hw/bmu_top.sv
verif/bmu_clk_gen.sv
verif/bmu_tb.sv

// File: Bender.yml
package:
  name: bmu

sources:
  - include_dirs:
      - hw
    files:
      - hw/bmu_pkg.sv
      - hw/bmu_b_decoder.sv
      - hw/bmu_b_alu.sv
      - hw/bmu_cmd_queue.sv
      - hw/bmu_exec_stage.sv
      - hw/bmu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/bmu_clk_gen.sv
      - verif/bmu_tb.sv
